// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --timing -Wall
TOP       := compute_tile_tb
FILELIST  := all.f
BUILD     := obj_dir
SIM_BIN   := $(BUILD)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(BUILD)

// ==== all.f ====
hdl/tile_pkg.sv
hdl/tile_bus_if.sv
hdl/tile_bus_arbiter.sv
hdl/tile_addr_decoder.sv
hdl/tile_data_mem.sv
hdl/tile_boot_rom.sv
hdl/compute_tile.sv
test/compute_tile_tb.sv

// ==== hdl/compute_tile.sv ====
// Compute tile memory system
`timescale 1ns/1ps
`default_nettype none

module compute_tile (
   input  wire                  clk,
   input  wire                  rst_n_i,
   // Instruction fetch port
   input  wire tile_pkg::addr_t iwb_adr_i,
   input  wire                  iwb_cyc_i,
   input  wire                  iwb_stb_i,
   output tile_pkg::data_t      iwb_rdat_o,
   output logic                 iwb_ack_o,
   output logic                 iwb_err_o,
   // Data port
   input  wire tile_pkg::addr_t dwb_adr_i,
   input  wire tile_pkg::data_t dwb_wdat_i,
   input  wire tile_pkg::sel_t  dwb_sel_i,
   input  wire                  dwb_we_i,
   input  wire                  dwb_cyc_i,
   input  wire                  dwb_stb_i,
   output tile_pkg::data_t      dwb_rdat_o,
   output logic                 dwb_ack_o,
   output logic                 dwb_err_o
);

   tile_bus_if shared_bus ();
   tile_bus_if mem_bus ();
   tile_bus_if rom_bus ();

   tile_bus_arbiter u_arbiter (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .iwb_adr_i  (iwb_adr_i),
      .iwb_cyc_i  (iwb_cyc_i),
      .iwb_stb_i  (iwb_stb_i),
      .iwb_rdat_o (iwb_rdat_o),
      .iwb_ack_o  (iwb_ack_o),
      .iwb_err_o  (iwb_err_o),
      .dwb_adr_i  (dwb_adr_i),
      .dwb_wdat_i (dwb_wdat_i),
      .dwb_sel_i  (dwb_sel_i),
      .dwb_we_i   (dwb_we_i),
      .dwb_cyc_i  (dwb_cyc_i),
      .dwb_stb_i  (dwb_stb_i),
      .dwb_rdat_o (dwb_rdat_o),
      .dwb_ack_o  (dwb_ack_o),
      .dwb_err_o  (dwb_err_o),
      .bus        (shared_bus.master)
   );

   tile_addr_decoder u_decoder (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .bus     (shared_bus.slave),
      .mem     (mem_bus.master),
      .rom     (rom_bus.master)
   );

   tile_data_mem u_data_mem (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .bus     (mem_bus.slave)
   );

   tile_boot_rom u_boot_rom (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .bus     (rom_bus.slave)
   );

endmodule

`default_nettype wire

// ==== hdl/tile_addr_decoder.sv ====
// Shared bus address decoder
`timescale 1ns/1ps
`default_nettype none

module tile_addr_decoder (
   input  wire        clk,
   input  wire        rst_n_i,
   tile_bus_if.slave  bus,
   tile_bus_if.master mem,
   tile_bus_if.master rom
);

   logic req;
   logic hit_mem, hit_rom;
   logic err_q;  // Reply for unmapped addresses

   assign req = bus.cyc & bus.stb;

   assign hit_mem = (bus.adr[tile_pkg::ADDR_W-1 -: tile_pkg::DM_RANGE_W]
                     == tile_pkg::DM_RANGE_MATCH);
   assign hit_rom = (bus.adr[tile_pkg::ADDR_W-1 -: tile_pkg::BOOT_RANGE_W]
                     == tile_pkg::BOOT_RANGE_MATCH);

   // Request fields fan out, strobes only to the selected slave
   assign mem.adr  = bus.adr;
   assign mem.wdat = bus.wdat;
   assign mem.sel  = bus.sel;
   assign mem.we   = bus.we;
   assign mem.cyc  = bus.cyc & hit_mem;
   assign mem.stb  = bus.stb & hit_mem;

   assign rom.adr  = bus.adr;
   assign rom.wdat = bus.wdat;
   assign rom.sel  = bus.sel;
   assign rom.we   = bus.we;
   assign rom.cyc  = bus.cyc & hit_rom;
   assign rom.stb  = bus.stb & hit_rom;

   // Single pulse, cleared while the same request is still held
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         err_q <= 1'b0;
      end else begin
         err_q <= req & ~hit_mem & ~hit_rom & ~err_q;
      end
   end

   always_comb begin
      if (hit_rom) begin
         bus.rdat = rom.rdat;
      end else if (hit_mem) begin
         bus.rdat = mem.rdat;
      end else begin
         bus.rdat = '0;
      end
   end

   assign bus.ack = (hit_mem & mem.ack) | (hit_rom & rom.ack);
   assign bus.err = (hit_mem & mem.err) | (hit_rom & rom.err) | err_q;

endmodule

`default_nettype wire

// ==== hdl/tile_boot_rom.sv ====
// Boot ROM
`timescale 1ns/1ps
`default_nettype none

module tile_boot_rom (
   input  wire       clk,
   input  wire       rst_n_i,
   tile_bus_if.slave bus
);

   tile_pkg::data_t     rdat_q;
   tile_pkg::boot_idx_t idx;
   logic req, ack_q, err_q;
   logic access;

   assign req    = bus.cyc & bus.stb;
   assign access = req & ~ack_q & ~err_q;
   assign idx    = bus.adr[tile_pkg::BOOT_IDX_W+1:2];

   always_ff @(posedge clk) begin
      if (access) rdat_q <= tile_pkg::boot_word(idx);
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ack_q <= 1'b0;
         err_q <= 1'b0;
      end else begin
         ack_q <= access & ~bus.we;
         err_q <= access & bus.we;  // Writes are refused
      end
   end

   assign bus.rdat = rdat_q;
   assign bus.ack  = ack_q;
   assign bus.err  = err_q;

endmodule

`default_nettype wire

// ==== hdl/tile_bus_arbiter.sv ====
// Round-robin arbiter for instruction and data ports
`timescale 1ns/1ps
`default_nettype none

module tile_bus_arbiter (
   input  wire                    clk,
   input  wire                    rst_n_i,
   // Instruction fetch port, reads only
   input  wire tile_pkg::addr_t   iwb_adr_i,
   input  wire                    iwb_cyc_i,
   input  wire                    iwb_stb_i,
   output tile_pkg::data_t        iwb_rdat_o,
   output logic                   iwb_ack_o,
   output logic                   iwb_err_o,
   // Data port
   input  wire tile_pkg::addr_t   dwb_adr_i,
   input  wire tile_pkg::data_t   dwb_wdat_i,
   input  wire tile_pkg::sel_t    dwb_sel_i,
   input  wire                    dwb_we_i,
   input  wire                    dwb_cyc_i,
   input  wire                    dwb_stb_i,
   output tile_pkg::data_t        dwb_rdat_o,
   output logic                   dwb_ack_o,
   output logic                   dwb_err_o,
   tile_bus_if.master             bus
);

   tile_pkg::arb_state_t state_q, state_d;
   logic last_ibus_q;  // Previous grant went to the fetch port
   logic ireq, dreq, done;
   logic igrant, dgrant;

   assign ireq   = iwb_cyc_i & iwb_stb_i;
   assign dreq   = dwb_cyc_i & dwb_stb_i;
   assign done   = bus.ack | bus.err;
   assign igrant = (state_q == tile_pkg::ARB_IBUS);
   assign dgrant = (state_q == tile_pkg::ARB_DBUS);

   always_comb begin
      state_d = state_q;
      case (state_q)
         tile_pkg::ARB_IDLE: begin
            if (ireq && (!dreq || !last_ibus_q)) begin  // Fetch wins only on its turn
               state_d = tile_pkg::ARB_IBUS;
            end else if (dreq) begin
               state_d = tile_pkg::ARB_DBUS;
            end
         end
         tile_pkg::ARB_IBUS: if (done || !iwb_cyc_i) state_d = tile_pkg::ARB_IDLE;
         tile_pkg::ARB_DBUS: if (done || !dwb_cyc_i) state_d = tile_pkg::ARB_IDLE;
         default:            state_d = tile_pkg::ARB_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q     <= tile_pkg::ARB_IDLE;
         last_ibus_q <= 1'b1;  // Data port goes first
      end else begin
         state_q <= state_d;
         if (state_q == tile_pkg::ARB_IDLE && state_d != tile_pkg::ARB_IDLE) begin
            last_ibus_q <= (state_d == tile_pkg::ARB_IBUS);
         end
      end
   end

   // Request path of the granted master
   always_comb begin
      bus.adr  = dwb_adr_i;
      bus.wdat = dwb_wdat_i;
      bus.sel  = dwb_sel_i;
      bus.we   = dwb_we_i;
      bus.cyc  = 1'b0;
      bus.stb  = 1'b0;
      if (igrant) begin
         bus.adr  = iwb_adr_i;
         bus.wdat = '0;
         bus.sel  = '1;  // Fetch reads the full word
         bus.we   = 1'b0;
         bus.cyc  = iwb_cyc_i;
         bus.stb  = iwb_stb_i;
      end else if (dgrant) begin
         bus.cyc = dwb_cyc_i;
         bus.stb = dwb_stb_i;
      end
   end

   // Responses go to the owner only
   assign iwb_rdat_o = igrant ? bus.rdat : '0;
   assign iwb_ack_o  = igrant & bus.ack;
   assign iwb_err_o  = igrant & bus.err;
   assign dwb_rdat_o = dgrant ? bus.rdat : '0;
   assign dwb_ack_o  = dgrant & bus.ack;
   assign dwb_err_o  = dgrant & bus.err;

endmodule

`default_nettype wire

// ==== hdl/tile_bus_if.sv ====
// Wishbone classic bus inside the tile
`timescale 1ns/1ps
`default_nettype none

interface tile_bus_if;

   tile_pkg::addr_t adr;
   tile_pkg::data_t wdat;
   tile_pkg::sel_t  sel;
   logic            we;
   logic            cyc;
   logic            stb;

   tile_pkg::data_t rdat;
   logic            ack;
   logic            err;

   modport master (
      output adr, wdat, sel, we, cyc, stb,
      input  rdat, ack, err
   );

   modport slave (
      input  adr, wdat, sel, we, cyc, stb,
      output rdat, ack, err
   );

endinterface

`default_nettype wire

// ==== hdl/tile_data_mem.sv ====
// Local data memory
`timescale 1ns/1ps
`default_nettype none

module tile_data_mem (
   input  wire       clk,
   input  wire       rst_n_i,
   tile_bus_if.slave bus
);

   tile_pkg::data_t   mem_q [tile_pkg::LMEM_WORDS];
   tile_pkg::data_t   rdat_q;
   tile_pkg::lmem_idx_t idx;
   logic req, ack_q;
   logic access;

   assign req    = bus.cyc & bus.stb;
   assign access = req & ~ack_q;  // First cycle of a request
   assign idx    = bus.adr[tile_pkg::LMEM_IDX_W+1:2];  // Wraps on word count

   always_ff @(posedge clk) begin
      if (access && bus.we) begin
         for (int b = 0; b < tile_pkg::SEL_W; b++) begin
            if (bus.sel[b]) begin
               mem_q[idx][8*b +: 8] <= bus.wdat[8*b +: 8];
            end
         end
      end
      if (access) begin
         rdat_q <= mem_q[idx];
      end
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= access;
      end
   end

   assign bus.rdat = rdat_q;
   assign bus.ack  = ack_q;
   assign bus.err  = 1'b0;  // Every word is backed

endmodule

`default_nettype wire

// ==== hdl/tile_pkg.sv ====
// Compute tile shared definitions
`default_nettype none

package tile_pkg;

   localparam int ADDR_W = 32;
   localparam int DATA_W = 32;
   localparam int SEL_W  = DATA_W / 8;  // One select bit per byte

   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [DATA_W-1:0] data_t;
   typedef logic [SEL_W-1:0]  sel_t;

   // Local data memory, lower half of the address space
   localparam int LMEM_WORDS = 256;
   localparam int LMEM_IDX_W = $clog2(LMEM_WORDS);

   typedef logic [LMEM_IDX_W-1:0] lmem_idx_t;

   // Range compare on the top address bits
   localparam int DM_RANGE_W = 1;
   localparam logic [DM_RANGE_W-1:0] DM_RANGE_MATCH = 1'b0;
   localparam int BOOT_RANGE_W = 4;
   localparam logic [BOOT_RANGE_W-1:0] BOOT_RANGE_MATCH = 4'hf;

   // Boot ROM, contents follow a fixed rule
   localparam int BOOT_WORDS = 16;
   localparam int BOOT_IDX_W = $clog2(BOOT_WORDS);
   localparam data_t BOOT_SIGNATURE = 32'h600d_b000;

   typedef logic [BOOT_IDX_W-1:0] boot_idx_t;

   // ROM word k reads as signature plus k
   function automatic data_t boot_word(boot_idx_t idx);
      return BOOT_SIGNATURE + data_t'(idx);
   endfunction

   // Shared bus owner
   typedef enum logic [1:0] {
      ARB_IDLE = 2'd0,
      ARB_IBUS = 2'd1,
      ARB_DBUS = 2'd2
   } arb_state_t;

endpackage

`default_nettype wire

// ==== test/compute_tile_tb.sv ====
// Compute tile testbench
`timescale 1ns/1ps
`default_nettype none

module compute_tile_tb;

   localparam int CLK_PERIOD   = 20;
   localparam int RESET_CYCLES = 10;
   localparam int N_XFER       = 200;  // Per port
   localparam int MAX_WAIT     = 20;
   localparam int TIMEOUT_NS   = (2 * N_XFER * 30 + RESET_CYCLES) * CLK_PERIOD;

   logic            clk, rst_n_i;
   tile_pkg::addr_t iwb_adr_i, dwb_adr_i;
   logic            iwb_cyc_i, iwb_stb_i, iwb_ack_o, iwb_err_o;
   tile_pkg::data_t iwb_rdat_o, dwb_rdat_o, dwb_wdat_i;
   tile_pkg::sel_t  dwb_sel_i;
   logic            dwb_we_i, dwb_cyc_i, dwb_stb_i, dwb_ack_o, dwb_err_o;

   int seed = 79;
   int errors = 0;

   // Stimulus, first index 0 for fetch and 1 for data
   tile_pkg::addr_t adr_s [2][N_XFER];
   int              gap_s [2][N_XFER];
   tile_pkg::data_t wdat_s [N_XFER];
   tile_pkg::sel_t  sel_s [N_XFER];
   logic            we_s [N_XFER];

   tile_pkg::data_t            model [tile_pkg::LMEM_WORDS];  // Shadow of the data memory
   logic [tile_pkg::SEL_W-1:0] known [tile_pkg::LMEM_WORDS];  // Bytes written so far
   logic [1:0]                 pending;
   int                         streak [2];  // Wins while the other port waits

   compute_tile u_compute_tile (
      .clk(clk), .rst_n_i(rst_n_i),
      .iwb_adr_i(iwb_adr_i), .iwb_cyc_i(iwb_cyc_i), .iwb_stb_i(iwb_stb_i),
      .iwb_rdat_o(iwb_rdat_o), .iwb_ack_o(iwb_ack_o), .iwb_err_o(iwb_err_o),
      .dwb_adr_i(dwb_adr_i), .dwb_wdat_i(dwb_wdat_i), .dwb_sel_i(dwb_sel_i),
      .dwb_we_i(dwb_we_i), .dwb_cyc_i(dwb_cyc_i), .dwb_stb_i(dwb_stb_i),
      .dwb_rdat_o(dwb_rdat_o), .dwb_ack_o(dwb_ack_o), .dwb_err_o(dwb_err_o)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // 0 memory, 1 boot ROM, 2 unmapped
   function automatic int region_of(input tile_pkg::addr_t a);
      if (a[31] == 1'b0) return 0;
      if (a[31:28] == 4'hf) return 1;
      return 2;
   endfunction

   function automatic tile_pkg::addr_t pick_addr();
      tile_pkg::addr_t a;
      int              region;
      a      = $random(seed);
      region = {$random(seed)} % 3;
      a[1:0] = 2'b00;
      a[9:6] = 4'h0;  // Sixteen words so reads meet earlier writes
      case (region)
         0:       a[31] = 1'b0;
         1:       a[31:28] = 4'hf;
         default: a[31:28] = 4'h8 + 4'({$random(seed)} % 7);
      endcase
      return a;
   endfunction

   task automatic quiet(input bit p, input int n);
      repeat (n) begin
         @(negedge clk);
         if (p ? (dwb_ack_o | dwb_err_o) : (iwb_ack_o | iwb_err_o)) begin
            $display("%0t: reply on the %s port with no open request", $time, p ? "dwb" : "iwb");
            errors++;
         end
      end
   endtask

   task automatic transfer(input bit p, input tile_pkg::addr_t adr, input logic we,
                           input tile_pkg::data_t wdat, input tile_pkg::sel_t sel,
                           input int gap);
      string               port;
      logic                ack, err, other_busy, want_err, other_reply;
      tile_pkg::data_t     rd, expect_rd, mask;
      tile_pkg::lmem_idx_t idx;
      int                  lat, region, b;
      port   = p ? "dwb" : "iwb";
      idx    = adr[tile_pkg::LMEM_IDX_W+1:2];
      region = region_of(adr);
      if (p) begin
         dwb_adr_i  = adr;
         dwb_wdat_i = wdat;
         dwb_sel_i  = sel;
         dwb_we_i   = we;
         dwb_cyc_i  = 1'b1;
         dwb_stb_i  = 1'b1;
      end else begin
         iwb_adr_i = adr;
         iwb_cyc_i = 1'b1;
         iwb_stb_i = 1'b1;
      end
      pending[p] = 1'b1;
      streak[!p] = 0;
      @(posedge clk);
      other_busy = p ? iwb_cyc_i : dwb_cyc_i;  // No contention at the sampling edge
      lat = 0;
      ack = 1'b0;
      err = 1'b0;
      other_reply = 1'b0;
      while (!ack && !err && lat < MAX_WAIT) begin
         @(negedge clk);
         lat++;
         ack = p ? dwb_ack_o : iwb_ack_o;
         err = p ? dwb_err_o : iwb_err_o;
         rd  = p ? dwb_rdat_o : iwb_rdat_o;
         other_reply = p ? (iwb_ack_o | iwb_err_o) : (dwb_ack_o | dwb_err_o);
      end
      pending[p] = 1'b0;
      want_err   = (region == 2) || (region == 1 && we);
      if (!ack && !err) begin
         $display("%0t: %s transfer to %h got no reply within %0d cycles",
                  $time, port, adr, MAX_WAIT);
         errors++;
      end else if (ack && err) begin
         $display("%0t: %s transfer to %h got ack and err together", $time, port, adr);
         errors++;
      end else begin
         if (err !== want_err) begin
            $display("error at %0t ns: %s_err_o expected %b, got %b", $time, port, want_err, err);
            errors++;
         end
         if (other_reply) begin
            $display("%0t: reply to the %s transfer also showed up on the other port",
                     $time, port);
            errors++;
         end
         streak[p]++;
         if (pending[!p] && streak[p] > 1) begin
            $display("%0t: %s port was granted twice while the other port waited", $time, port);
            errors++;
         end
         if (!other_busy && lat != 2) begin
            $display("%0t: lone %s request replied after %0d cycles instead of 2",
                     $time, port, lat);
            errors++;
         end
         if (ack && !we && region != 2) begin
            mask = '1;
            expect_rd = tile_pkg::BOOT_SIGNATURE + tile_pkg::data_t'(adr[5:2]);
            if (region == 0) begin
               expect_rd = model[idx];
               for (b = 0; b < tile_pkg::SEL_W; b++) begin
                  if (!known[idx][b]) mask[8*b +: 8] = 8'h00;  // Never written
               end
            end
            if ((rd & mask) !== (expect_rd & mask)) begin
               $display("error at %0t ns: %s_rdat_o expected %h, got %h",
                        $time, port, expect_rd & mask, rd & mask);
               errors++;
            end
         end
         if (ack && we && region == 0) begin
            for (b = 0; b < tile_pkg::SEL_W; b++) begin
               if (sel[b]) begin
                  model[idx][8*b +: 8] = wdat[8*b +: 8];
                  known[idx][b]        = 1'b1;
               end
            end
         end
      end
      quiet(p, 1);  // Pulse must not repeat
      if (p) begin
         dwb_cyc_i = 1'b0;
         dwb_stb_i = 1'b0;
      end else begin
         iwb_cyc_i = 1'b0;
         iwb_stb_i = 1'b0;
      end
      quiet(p, gap);
   endtask

   initial begin
      int i, fi, di;
      rst_n_i    = 1'b0;
      iwb_adr_i  = '0;
      iwb_cyc_i  = 1'b0;
      iwb_stb_i  = 1'b0;
      dwb_adr_i  = '0;
      dwb_wdat_i = '0;
      dwb_sel_i  = '0;
      dwb_we_i   = 1'b0;
      dwb_cyc_i  = 1'b0;
      dwb_stb_i  = 1'b0;
      pending    = '0;
      streak[0]  = 0;
      streak[1]  = 0;
      for (i = 0; i < tile_pkg::LMEM_WORDS; i++) known[i] = '0;
      for (i = 0; i < N_XFER; i++) begin
         adr_s[0][i] = pick_addr();
         gap_s[0][i] = {$random(seed)} % 4;
         adr_s[1][i] = pick_addr();
         gap_s[1][i] = {$random(seed)} % 4;
         wdat_s[i]   = $random(seed);
         sel_s[i]    = tile_pkg::sel_t'($random(seed));
         we_s[i]     = 1'($random(seed));
      end
      repeat (RESET_CYCLES) begin
         @(negedge clk);
         if (iwb_ack_o | iwb_err_o | dwb_ack_o | dwb_err_o) begin
            $display("%0t: reply seen while reset is asserted", $time);
            errors++;
         end
      end
      rst_n_i = 1'b1;
      fork
         quiet(1'b0, 2);
         quiet(1'b1, 2);
      join
      fork
         begin
            for (fi = 0; fi < N_XFER; fi++)
               transfer(1'b0, adr_s[0][fi], 1'b0, '0, '1, gap_s[0][fi]);
         end
         begin
            for (di = 0; di < N_XFER; di++)
               transfer(1'b1, adr_s[1][di], we_s[di], wdat_s[di], sel_s[di], gap_s[1][di]);
         end
      join
      $display("Transfers done, error count %0d", errors);
      if (errors == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

   // Watchdog
   initial begin
      #(TIMEOUT_NS);
      $display("Watchdog expired before all transfers finished");
      $display("ERRORS FOUND");
      $finish;
   end

endmodule

`default_nettype wire
